//--- Bender.yml
package:
  name: scalar_unit

sources:
  - scalar_pkg.sv
  - exec_if.sv
  - instr_mem.sv
  - pc_unit.sv
  - reg_file.sv
  - scalar_alu.sv
  - issue_ctrl.sv
  - scalar_unit.sv
  - target: test
    files:
      - tb_scalar_unit.sv

//--- all.f
scalar_pkg.sv
exec_if.sv
instr_mem.sv
pc_unit.sv
reg_file.sv
scalar_alu.sv
issue_ctrl.sv
scalar_unit.sv
tb_scalar_unit.sv

//--- exec_if.sv
/*
 * Decoded instruction fields and the execute strobe,
 * with views for control, register file and ALU
 */
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
	import scalar_pkg::*;

	opcode_t op;
	reg_idx_t dst;
	reg_idx_t src1;
	reg_idx_t src2;
	imm_t imm;

	// High for the single EXEC cycle of each instruction
	logic exec;

	modport ctrl (
		output op,
		output dst,
		output src1,
		output src2,
		output imm,
		output exec
	);

	modport regs (
		input dst,
		input src1,
		input src2,
		input exec
	);

	modport alu (
		input op,
		input imm,
		input exec
	);

endinterface

`default_nettype wire

//--- instr_mem.sv
/*
 * Instruction memory with a write port for program
 * loading and a registered read port for fetch
 */
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
	parameter int ADDR_WIDTH = 8
) (
	input logic clock,
	input logic store,
	input logic [ADDR_WIDTH-1:0] store_addr,
	input scalar_pkg::instr_t store_instr,
	input logic fetch,
	input logic [ADDR_WIDTH-1:0] pc,
	output scalar_pkg::instr_t instr
);
	import scalar_pkg::*;

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	instr_t mem [DEPTH];

	// Program load, already gated with busy at the top
	always_ff @(posedge clock) begin
		if (store) begin
			mem[store_addr] <= store_instr;
		end
	end

	// Fetch register holds the word for the EXEC cycle
	always_ff @(posedge clock) begin
		if (fetch) begin
			instr <= mem[pc];
		end
	end

endmodule

`default_nettype wire

//--- issue_ctrl.sv
/*
 * Control FSM sequencing FETCH and EXEC per instruction,
 * run start and HALT detection
 */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
	input logic clock,
	input logic reset,
	input logic start,
	input scalar_pkg::instr_t instr,
	output logic fetch,
	output logic step,
	output logic restart,
	output logic busy,
	output logic term,
	exec_if.ctrl ex
);
	import scalar_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		EXEC
	} state_t;

	state_t state;
	state_t state_next;
	logic is_halt;

	assign is_halt = (instr.op == HALT);

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = FETCH;
				end
			end
			FETCH: begin
				state_next = EXEC;
			end
			EXEC: begin
				// HALT ends the run, anything else fetches the next word
				if (is_halt) begin
					state_next = IDLE;
				end else begin
					state_next = FETCH;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobes
	////////////////////////////////////////////////////////////////////////////

	// Start while idle clears the PC at the same edge
	assign restart = (state == IDLE) && start;
	assign fetch = (state == FETCH);
	assign step = (state == EXEC);
	assign busy = (state != IDLE);
	assign term = (state == EXEC) && is_halt;

	// Fetched word goes straight to the datapath
	assign ex.op = instr.op;
	assign ex.dst = instr.dst;
	assign ex.src1 = instr.src1;
	assign ex.src2 = instr.src2;
	assign ex.imm = instr.imm;
	assign ex.exec = step;

endmodule

`default_nettype wire

//--- pc_unit.sv
/*
 * Program counter with restart, sequential step
 * and jump or branch load
 */
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
	parameter int ADDR_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input logic restart,
	input logic step,
	input logic taken,
	input logic [ADDR_WIDTH-1:0] target,
	output logic [ADDR_WIDTH-1:0] pc
);

	logic [ADDR_WIDTH-1:0] pc_next;

	// Increment wraps at the end of instruction memory
	always_comb begin
		pc_next = pc;
		if (restart) begin
			pc_next = '0;
		end else if (step) begin
			if (taken) begin
				pc_next = target;
			end else begin
				pc_next = pc + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- reg_file.sv
/*
 * Sixteen-entry register file
 * Two combinational read ports, one write port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input logic clock,
	input logic reset,
	exec_if.regs rf,
	input logic wb_en,
	input scalar_pkg::data_t wb_data,
	output scalar_pkg::data_t src1_data,
	output scalar_pkg::data_t src2_data
);
	import scalar_pkg::*;

	data_t regs [NUM_REGS];

	// Operand read during the EXEC cycle
	assign src1_data = regs[rf.src1];
	assign src2_data = regs[rf.src2];

	// Result lands at the end of EXEC
	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (rf.exec && wb_en) begin
			regs[rf.dst] <= wb_data;
		end
	end

endmodule

`default_nettype wire

//--- scalar_alu.sv
/*
 * Scalar ALU with write-back decision, condition register,
 * branch decision and OUT strobe
 */
`timescale 1ns/1ps
`default_nettype none

module scalar_alu #(
	parameter int ADDR_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	exec_if.alu alu,
	input scalar_pkg::data_t src1_data,
	input scalar_pkg::data_t src2_data,
	output logic wb_en,
	output scalar_pkg::data_t wb_data,
	output logic taken,
	output logic [ADDR_WIDTH-1:0] target,
	output logic out_valid,
	output scalar_pkg::data_t out_data
);
	import scalar_pkg::*;

	localparam int IMM_WIDTH = $bits(imm_t);

	logic cond;
	logic cond_we;
	logic cond_next;

	////////////////////////////////////////////////////////////////////////////
	// Result and write-back
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		wb_en = 1'b0;
		wb_data = '0;
		case (alu.op)
			MOVI: begin
				wb_en = 1'b1;
				wb_data = {{(DATA_WIDTH-IMM_WIDTH){alu.imm[IMM_WIDTH-1]}}, alu.imm};
			end
			ADD: begin
				wb_en = 1'b1;
				wb_data = src1_data + src2_data;
			end
			SUB: begin
				wb_en = 1'b1;
				wb_data = src1_data - src2_data;
			end
			AND: begin
				wb_en = 1'b1;
				wb_data = src1_data & src2_data;
			end
			OR: begin
				wb_en = 1'b1;
				wb_data = src1_data | src2_data;
			end
			XOR: begin
				wb_en = 1'b1;
				wb_data = src1_data ^ src2_data;
			end
			SHL: begin
				wb_en = 1'b1;
				wb_data = src1_data << src2_data[4:0];
			end
			default: begin
				wb_en = 1'b0;
			end
		endcase
		wb_en = wb_en & alu.exec;
	end

	////////////////////////////////////////////////////////////////////////////
	// Condition register
	////////////////////////////////////////////////////////////////////////////

	assign cond_we = alu.exec && (alu.op == CMPEQ || alu.op == CMPLT);

	// CMPLT compares as signed
	assign cond_next = (alu.op == CMPEQ) ? (src1_data == src2_data)
		: ($signed(src1_data) < $signed(src2_data));

	always_ff @(posedge clock) begin
		if (reset) begin
			cond <= 1'b0;
		end else if (cond_we) begin
			cond <= cond_next;
		end
	end

	// Jump target from the low immediate bits
	assign target = ADDR_WIDTH'(alu.imm);
	assign taken = alu.exec && (alu.op == JMP || (alu.op == BRC && cond));

	assign out_valid = alu.exec && (alu.op == OUT);
	assign out_data = src1_data;

endmodule

`default_nettype wire

//--- scalar_pkg.sv
/*
 * Shared widths, data types, opcode encoding and
 * packed instruction format of the scalar unit
 */
`default_nettype none

package scalar_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH = 32;
	localparam int NUM_REGS = 16;

	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [15:0] imm_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	// Encodings 14 and 15 are unassigned and execute as NOP
	typedef enum logic [3:0] {
		NOP   = 4'd0,
		MOVI  = 4'd1,
		ADD   = 4'd2,
		SUB   = 4'd3,
		AND   = 4'd4,
		OR    = 4'd5,
		XOR   = 4'd6,
		SHL   = 4'd7,
		CMPEQ = 4'd8,
		CMPLT = 4'd9,
		JMP   = 4'd10,
		BRC   = 4'd11,
		OUT   = 4'd12,
		HALT  = 4'd13
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////////////////////

	// Fields from the top: op, dst, src1, src2, imm
	typedef struct packed {
		opcode_t op;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t imm;
	} instr_t;

endpackage

`default_nettype wire

//--- scalar_unit.sv
/*
 * Scalar unit top level
 * Control FSM, PC, instruction memory, register file and ALU
 */
`timescale 1ns/1ps
`default_nettype none

module scalar_unit #(
	parameter int ADDR_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input logic store,
	input logic [ADDR_WIDTH-1:0] store_addr,
	input scalar_pkg::instr_t store_instr,
	input logic start,
	output logic busy,
	output logic out_valid,
	output scalar_pkg::data_t out_data,
	output logic term
);
	import scalar_pkg::*;

	instr_t instr;
	logic fetch;
	logic step;
	logic restart;
	logic store_en;
	logic [ADDR_WIDTH-1:0] pc;
	logic taken;
	logic [ADDR_WIDTH-1:0] target;
	logic wb_en;
	data_t wb_data;
	data_t src1_data;
	data_t src2_data;

	exec_if ex ();

	// Program is frozen during a run
	assign store_en = store && !busy;

	issue_ctrl u_issue_ctrl (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.instr   (instr),
		.fetch   (fetch),
		.step    (step),
		.restart (restart),
		.busy    (busy),
		.term    (term),
		.ex      (ex.ctrl)
	);

	pc_unit #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_pc_unit (
		.clock   (clock),
		.reset   (reset),
		.restart (restart),
		.step    (step),
		.taken   (taken),
		.target  (target),
		.pc      (pc)
	);

	instr_mem #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_instr_mem (
		.clock       (clock),
		.store       (store_en),
		.store_addr  (store_addr),
		.store_instr (store_instr),
		.fetch       (fetch),
		.pc          (pc),
		.instr       (instr)
	);

	reg_file u_reg_file (
		.clock     (clock),
		.reset     (reset),
		.rf        (ex.regs),
		.wb_en     (wb_en),
		.wb_data   (wb_data),
		.src1_data (src1_data),
		.src2_data (src2_data)
	);

	scalar_alu #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_scalar_alu (
		.clock     (clock),
		.reset     (reset),
		.alu       (ex.alu),
		.src1_data (src1_data),
		.src2_data (src2_data),
		.wb_en     (wb_en),
		.wb_data   (wb_data),
		.taken     (taken),
		.target    (target),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

//--- tb_scalar_unit.sv
/*
 * Testbench for the scalar unit with a reference instruction model
 * Arithmetic, branch, jump, halt and restart programs
 */
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_unit;
	import scalar_pkg::*;

	localparam int ADDR_WIDTH = 8;
	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam int RUN_LIMIT = 2000;

	logic clock;
	logic reset;
	logic store;
	logic [ADDR_WIDTH-1:0] store_addr;
	instr_t store_instr;
	logic start;
	logic busy;
	logic out_valid;
	data_t out_data;
	logic term;

	instr_t prog [DEPTH];
	int prog_len;
	data_t model_regs [NUM_REGS];
	logic model_cond;
	data_t exp_q [$];
	data_t got_q [$];
	data_t first_q [$];
	logic [31:0] rng;

	scalar_unit #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) uut (
		.clock       (clock),
		.reset       (reset),
		.store       (store),
		.store_addr  (store_addr),
		.store_instr (store_instr),
		.start       (start),
		.busy        (busy),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.term        (term)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			report_failure($sformatf("FAILED %s expected 0x%08h got 0x%08h",
				name, expected, actual));
	endtask

	task automatic compare_outputs();
		check_value("out_valid count", exp_q.size(), got_q.size());
		foreach (got_q[i]) begin
			check_value("out_data", exp_q[i], got_q[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program building and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic instr_t make_instr(input opcode_t op, input logic [3:0] dst,
			input logic [3:0] src1, input logic [3:0] src2, input logic [15:0] imm);
		instr_t w;
		w.op = op;
		w.dst = dst;
		w.src1 = src1;
		w.src2 = src2;
		w.imm = imm;
		return w;
	endfunction

	task automatic append_instr(input opcode_t op, input logic [3:0] dst,
			input logic [3:0] src1, input logic [3:0] src2, input logic [15:0] imm);
		prog[prog_len] = make_instr(op, dst, src1, src2, imm);
		prog_len++;
	endtask

	// Executes prog from address 0; register and condition state carry over
	task automatic model_run();
		instr_t w;
		data_t a;
		data_t b;
		int addr;
		int next_addr;
		int n;
		exp_q.delete();
		addr = 0;
		for (n = 0; n < RUN_LIMIT; n++) begin
			if (addr >= prog_len) begin
				report_failure("reference model ran past the end of the program");
			end
			w = prog[addr];
			a = model_regs[w.src1];
			b = model_regs[w.src2];
			next_addr = (addr + 1) % DEPTH;
			case (w.op)
				MOVI: model_regs[w.dst] = 32'($signed(w.imm));
				ADD: model_regs[w.dst] = a + b;
				SUB: model_regs[w.dst] = a - b;
				AND: model_regs[w.dst] = a & b;
				OR: model_regs[w.dst] = a | b;
				XOR: model_regs[w.dst] = a ^ b;
				SHL: model_regs[w.dst] = a << b[4:0];
				CMPEQ: model_cond = (a == b);
				CMPLT: model_cond = ($signed(a) < $signed(b));
				JMP: next_addr = int'(w.imm) % DEPTH;
				BRC: if (model_cond) next_addr = int'(w.imm) % DEPTH;
				OUT: exp_q.push_back(a);
				HALT: return;
				default: ;
			endcase
			addr = next_addr;
		end
		report_failure("reference model did not reach HALT");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// DUT access
	////////////////////////////////////////////////////////////////////////////

	task automatic load_program();
		int i;
		for (i = 0; i < prog_len; i++) begin
			@(negedge clock);
			store = 1'b1;
			store_addr = i[ADDR_WIDTH-1:0];
			store_instr = prog[i];
		end
		@(negedge clock);
		store = 1'b0;
	endtask

	// Optionally tries to overwrite address 4 while the run is going
	task automatic run_program(input bit store_while_busy);
		int cycles;
		int terms;
		got_q.delete();
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		cycles = 0;
		while (busy !== 1'b1) begin
			if (cycles >= 4) begin
				report_failure("timed out waiting for busy to rise after start");
			end
			@(negedge clock);
			cycles++;
		end
		cycles = 0;
		terms = 0;
		while (busy === 1'b1) begin
			if (out_valid === 1'b1) begin
				got_q.push_back(out_data);
			end
			if (term === 1'b1) begin
				terms++;
			end
			store = store_while_busy && (cycles == 2);
			store_addr = 4;
			store_instr = make_instr(OUT, 0, 2, 0, 0);
			if (cycles >= RUN_LIMIT) begin
				report_failure("timed out waiting for the run to end");
			end
			@(negedge clock);
			cycles++;
		end
		store = 1'b0;
		check_value("term pulses", 1, terms);
		// Nothing may follow the end of the run
		repeat (5) begin
			check_value("out_valid", 0, out_valid);
			check_value("term", 0, term);
			check_value("busy", 0, busy);
			@(negedge clock);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		store = 1'b0;
		store_addr = '0;
		store_instr = '0;
		start = 1'b0;
		rng = 32'h495f;
		model_regs = '{default: '0};
		model_cond = 1'b0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_value("busy", 0, busy);
		check_value("out_valid", 0, out_valid);
		check_value("term", 0, term);

		// Arithmetic with random operands
		prog_len = 0;
		rng = xorshift(rng);
		append_instr(MOVI, 1, 0, 0, rng[15:0]);
		rng = xorshift(rng);
		append_instr(MOVI, 2, 0, 0, rng[15:0]);
		rng = xorshift(rng);
		append_instr(MOVI, 3, 0, 0, rng[15:0]);
		append_instr(ADD, 4, 1, 2, 0);
		append_instr(OUT, 0, 4, 0, 0);
		append_instr(SUB, 5, 1, 2, 0);
		append_instr(OUT, 0, 5, 0, 0);
		append_instr(AND, 6, 1, 2, 0);
		append_instr(OUT, 0, 6, 0, 0);
		append_instr(OR, 7, 1, 2, 0);
		append_instr(OUT, 0, 7, 0, 0);
		append_instr(XOR, 8, 1, 2, 0);
		append_instr(OUT, 0, 8, 0, 0);
		append_instr(SHL, 9, 1, 3, 0);
		append_instr(OUT, 0, 9, 0, 0);
		append_instr(OUT, 0, 1, 0, 0);
		append_instr(HALT, 0, 0, 0, 0);
		load_program();
		model_run();
		run_program(1'b0);
		compare_outputs();

		// Countdown loop, then signed compares
		prog_len = 0;
		rng = xorshift(rng);
		append_instr(MOVI, 1, 0, 0, 16'(rng % 6 + 2));
		append_instr(MOVI, 2, 0, 0, 1);
		append_instr(MOVI, 0, 0, 0, 0);
		append_instr(OUT, 0, 1, 0, 0);
		append_instr(SUB, 1, 1, 2, 0);
		append_instr(CMPEQ, 0, 1, 0, 0);
		append_instr(BRC, 0, 0, 0, 8);
		append_instr(JMP, 0, 0, 0, 3);
		append_instr(MOVI, 5, 0, 0, 16'hfff9);
		append_instr(MOVI, 6, 0, 0, 3);
		append_instr(CMPLT, 0, 5, 6, 0);
		append_instr(BRC, 0, 0, 0, 14);
		append_instr(OUT, 0, 6, 0, 0);
		append_instr(HALT, 0, 0, 0, 0);
		append_instr(OUT, 0, 5, 0, 0);
		append_instr(CMPLT, 0, 6, 5, 0);
		append_instr(BRC, 0, 0, 0, 13);
		append_instr(OUT, 0, 6, 0, 0);
		append_instr(HALT, 0, 0, 0, 0);
		load_program();
		model_run();
		run_program(1'b0);
		compare_outputs();

		// JMP over an OUT of r2
		prog_len = 0;
		rng = xorshift(rng);
		append_instr(MOVI, 1, 0, 0, rng[15:0]);
		append_instr(MOVI, 2, 0, 0, ~rng[15:0]);
		append_instr(JMP, 0, 0, 0, 4);
		append_instr(OUT, 0, 2, 0, 0);
		append_instr(OUT, 0, 1, 0, 0);
		append_instr(HALT, 0, 0, 0, 0);
		load_program();
		model_run();
		run_program(1'b0);
		foreach (got_q[i]) begin
			assert (got_q[i] !== model_regs[2]) else
				report_failure("the OUT skipped by JMP still produced its value");
		end
		compare_outputs();

		// Halt, store during a run, then a second start
		prog_len = 0;
		rng = xorshift(rng);
		append_instr(MOVI, 1, 0, 0, rng[15:0]);
		rng = xorshift(rng);
		append_instr(MOVI, 2, 0, 0, rng[15:0]);
		append_instr(ADD, 3, 1, 2, 0);
		append_instr(OUT, 0, 1, 0, 0);
		append_instr(OUT, 0, 3, 0, 0);
		append_instr(XOR, 4, 3, 2, 0);
		append_instr(OUT, 0, 4, 0, 0);
		append_instr(HALT, 0, 0, 0, 0);
		load_program();
		model_run();
		run_program(1'b1);
		compare_outputs();
		first_q = got_q;
		run_program(1'b0);
		check_value("repeat out_valid count", first_q.size(), got_q.size());
		foreach (got_q[i]) begin
			check_value("repeat out_data", first_q[i], got_q[i]);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
